/* filelist.f */
rtl/ctlPkg.sv
rtl/ctlSpecDecode.sv
rtl/ctlRegControl.sv
rtl/ctlDiagDecode.sv
rtl/ctlDiagRead.sv
rtl/ctlTop.sv
sim/ctlTb.sv

/* sim/ctlTb.sv */
// Control decoder testbench
module ctlTb;

  localparam int numCycles = 2000;
  localparam int clkPeriod = 4;

  logic CTL = 1'b0;
  logic arstN;
  ctlPkg::cramT cram;
  ctlPkg::boardStatT stat;
  ctlPkg::ebusT ebus;
  ctlPkg::specT spec;
  ctlPkg::regCtlT regCtl;
  ctlPkg::diagFuncT diagFunc;
  ctlPkg::diagRegT diagReg;
  logic loadPc;
  logic adxCry36;
  ctlPkg::readBusT readBus;

  // Model state for the two registers
  logic pcModel;
  ctlPkg::diagRegT regModel;
  int cycleNo;

  // Code tables in specT field order
  logic [ctlPkg::dispW-1:0] dispCodes [7];
  logic [ctlPkg::specW-1:0] specCodes [13];

  ctlTop ctlTop_i (
    .CTL(CTL), .arstN(arstN), .cram(cram), .stat(stat), .ebus(ebus),
    .spec(spec), .regCtl(regCtl), .diagFunc(diagFunc), .diagReg(diagReg),
    .loadPc(loadPc), .adxCry36(adxCry36), .readBus(readBus)
  );

  always #(clkPeriod / 2) CTL = ~CTL;

  task automatic stopRun(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at cycle %0d", cycleNo);
  endtask

  initial begin
    #((numCycles + 20) * clkPeriod);
    stopRun("Timeout: the test loop did not finish in time");
  end

  task automatic checkSpec(string name, ctlPkg::specT exp, ctlPkg::specT act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %h actual %h", name, cycleNo, exp, act));
    end
  endtask

  task automatic checkRegCtl(string name, ctlPkg::regCtlT exp, ctlPkg::regCtlT act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %h actual %h", name, cycleNo, exp, act));
    end
  endtask

  task automatic checkDiagFunc(string name, ctlPkg::diagFuncT exp, ctlPkg::diagFuncT act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %h actual %h", name, cycleNo, exp, act));
    end
  endtask

  task automatic checkDiagReg(string name, ctlPkg::diagRegT exp, ctlPkg::diagRegT act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %h actual %h", name, cycleNo, exp, act));
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %b actual %b", name, cycleNo, exp, act));
    end
  endtask

  task automatic checkReadBus(string name, ctlPkg::readBusT exp, ctlPkg::readBusT act);
    if (act !== exp) begin
      stopRun($sformatf("MISMATCH %s cycle %0d expected %h actual %h", name, cycleNo, exp, act));
    end
  endtask

  function automatic ctlPkg::specT specModel(ctlPkg::cramT c, ctlPkg::boardStatT s);
    ctlPkg::specT e;
    logic [0:6] dFlag;
    logic [0:12] sFlag;
    for (int i = 0; i < 7; i++) begin
      dFlag[i] = c.disp == dispCodes[i];
    end
    for (int i = 0; i < 13; i++) begin
      sFlag[i] = c.spec == specCodes[i];
    end
    e = {dFlag, sFlag, 2'b00};
    e.adLong = e.dMul | e.dDiv | e.dNorm | e.sAdLong | e.sMqShift;
    e.genCry18 = e.sGenCry18 | (e.sStackUpdate & s.shortStack);
    return e;
  endfunction

  function automatic ctlPkg::diagFuncT diagFuncModel(ctlPkg::cramT c, ctlPkg::boardStatT s,
                                                     ctlPkg::ebusT b);
    ctlPkg::diagFuncT d;
    logic [0:6] sel;
    d = '0;
    d.consoleControl = b.ds[0] | b.ds[1];
    sel = d.consoleControl ? b.ds : c.magic.regCtl[2:8];
    if (b.diagStrobe && !b.ds[0]) begin
      case (b.ds[1:3])
        3'o0: d.ctlFunc00x = 1'b1;
        3'o1: d.ctlFunc01x = 1'b1;
        3'o4: d.ldFunc04x = 1'b1;
        3'o5: d.ldFunc05x = 1'b1;
        3'o6: d.ldFunc06x = 1'b1;
        3'o7: d.ldFunc07x = 1'b1;
        default: ;
      endcase
    end
    if (d.ldFunc07x) begin
      d.func07x[b.ds[4:6]] = 1'b1;
    end
    d.readStrobe = d.consoleControl ? b.diagStrobe : s.condDiagFunc;
    d.readEn = d.readStrobe & sel[0];
    d.readSel = sel[1:3];
    d.diagRead = d.readEn && sel[1:3] == 3'o0;
    d.grp = sel[4:6];
    d.diagArLoad = sel[0] && b.ds[1:3] == 3'o7 && sel[4:6] == 3'o7;
    return d;
  endfunction

  function automatic ctlPkg::regCtlT regCtlModel(ctlPkg::cramT c, ctlPkg::boardStatT s,
                                                 ctlPkg::specT sp, logic dal);
    ctlPkg::regCtlT r;
    logic [2:0] cc;
    logic [2:0] sel;
    logic [0:8] en;
    logic ind;
    logic clL;
    logic clR;
    logic fmAr;
    logic fmArx;
    logic ms;
    logic rst;
    logic math;
    r = '0;
    cc = s.condEn ? c.cond[3:5] : 3'd0;
    ind = s.memArlInd | sp.sArlInd | (cc == 3'd6);
    en = (!ind && cc == 3'd7) ? c.magic.regCtl : '0;
    if (ind) begin
      sel = c.magic.arlInd.arlSel;
      clL = c.magic.arlInd.arClrL;
      clR = c.magic.arlInd.arClrR;
      r.mqClr = c.magic.arlInd.mqClr;
      r.arxClr = c.magic.arlInd.arxClr;
    end else begin
      sel = c.ar;
      clL = cc == 3'd4;
      clR = cc == 3'd4;
      r.arxClr = cc == 3'd5;
    end
    fmAr = s.fmXfer & s.loadAr;
    fmArx = s.fmXfer & s.loadArx;
    ms = s.respMbox | s.respSim;
    r.ar1217Clr = s.mrReset | s.ea18 | clL | (sp.dEaMod & s.arx18);
    r.ar0011Clr = r.ar1217Clr | s.ea23;
    r.arrClr = s.mrReset | clR;
    r.arlSel[2] = sel[2];
    r.arlSel[1] = sel[1] | (sp.dARead & r.ar0011Clr) | dal | fmAr;
    r.arlSel[0] = sel[0] | dal | (s.loadAr & ms);
    r.arrSel = {c.ar[1] | sp.dARead | dal | fmAr, c.ar[2] | dal | (s.loadAr & ms)};
    r.ar0917Load = (cc == 3'd2) | en[1] | r.ar0011Clr | (|r.arlSel);
    r.ar0008Load = (cc == 3'd1) | en[0] | r.ar0011Clr | (|r.arlSel) |
                   (ind & c.magic.arlInd.callSel);
    r.arrLoad = en[2] | (cc == 3'd3) | r.arrClr | (|r.arrSel);
    r.arxlSel = {c.arx[1] | fmArx, c.arx[2] | (s.loadArx & ms)};
    r.arxrSel = r.arxlSel;
    r.arxLoad = c.arx[0] | (|r.arxlSel) | r.arxClr | s.mrReset;
    r.ebusXfer = c.ar[0] & s.cono & !(c.ar[1] & c.ar[2]);
    rst = s.mrReset | en[7] | r.mqClr;
    math = r.mqClr | en[8] | sp.sMqShift | sp.dMul | sp.dDiv;
    r.mqmEn = c.mq | s.mrReset;
    r.mqmSel = r.mqmEn ? {rst, math} : 2'b00;
    r.mqSel = r.mqmEn ? 2'b00 : {rst, math};
    return r;
  endfunction

  // Read table by columns indexed by select bits 5 and 6
  function automatic ctlPkg::readBusT readBusModel(ctlPkg::specT sp, ctlPkg::regCtlT r,
                                                   ctlPkg::diagFuncT d, ctlPkg::diagRegT g,
                                                   logic pc, logic cry);
    ctlPkg::readBusT rb;
    logic [3:0] col0;
    logic [3:0] col1;
    logic [3:0] col2;
    logic [3:0] col3;
    logic [3:0] col4;
    logic [1:0] idx;
    col0 = {sp.sInhCry18, sp.adLong, sp.sSpMemCycle, sp.sFlagCtl};
    col1 = {g.memReset, cry, sp.sXcryAr0, pc};
    col2 = {r.arxrSel[0], r.arxrSel[1], r.arxlSel[0], r.arxlSel[1]};
    col3 = {g.ldEbusReg, r.mqmEn, r.mqSel[0], r.mqSel[1]};
    col4 = {r.ebusXfer, r.arrClr, r.ar1217Clr, r.ar0011Clr};
    idx = d.grp[1:2];
    rb.driving = d.diagRead;
    rb.data = '0;
    if (d.diagRead && d.grp[0]) begin
      rb.data = {col0[idx], col1[idx], col2[idx], col3[idx], col4[idx]};
    end
    return rb;
  endfunction

  task automatic driveRandom();
    logic [63:0] bits;
    logic [63:0] more;
    logic [2:0] di;
    logic [3:0] si;
    ctlPkg::cramT c;
    ctlPkg::boardStatT s;
    ctlPkg::ebusT b;
    bits = {$urandom(), $urandom()};
    more = {$urandom(), $urandom()};
    c = bits[32:0];
    s = more[17:0];
    b = more[30:18];
    // A third of the words carry valid codes
    if ($urandom_range(2) == 0) begin
      di = 3'($urandom_range(6));
      si = 4'($urandom_range(12));
      c.disp = dispCodes[di];
      c.spec = specCodes[si];
    end
    s.mrReset = s.mrReset & ($urandom_range(7) == 0);
    if ($urandom_range(7) == 0) begin
      b.ds = {1'b0, ctlPkg::diagLdFunc076};
    end
    cram <= c;
    stat <= s;
    ebus <= b;
  endtask

  task automatic compareOutputs();
    ctlPkg::specT eSpec;
    ctlPkg::diagFuncT eDiag;
    ctlPkg::regCtlT eReg;
    logic eCry;
    logic ePc;
    eSpec = specModel(cram, stat);
    eDiag = diagFuncModel(cram, stat, ebus);
    eReg = regCtlModel(cram, stat, eSpec, eDiag.diagArLoad);
    if (stat.pcPlus1Inh && cram.spec == ctlPkg::specSaveFlags) begin
      eCry = 1'b0;
    end else begin
      eCry = cram.adCarry ^ (stat.ar0 && cram.spec == ctlPkg::specXcryAr0);
    end
    ePc = pcModel & !stat.piCycle;
    checkSpec("specDecode", eSpec, spec);
    checkRegCtl("regControl", eReg, regCtl);
    checkDiagFunc("diagDecode", eDiag, diagFunc);
    checkDiagReg("diagRegister", regModel, diagReg);
    checkBit("adxCry36", eCry, adxCry36);
    checkBit("loadPc", ePc, loadPc);
    checkReadBus("diagRead", readBusModel(eSpec, eReg, eDiag, regModel, ePc, eCry), readBus);
  endtask

  initial begin
    void'($urandom(44));
    dispCodes = '{ctlPkg::dispDramARd, ctlPkg::dispReturn, ctlPkg::dispNiCond,
                  ctlPkg::dispMul, ctlPkg::dispDiv, ctlPkg::dispNorm, ctlPkg::dispEaMod};
    specCodes = '{ctlPkg::specInhCry18, ctlPkg::specMqShift, ctlPkg::specScmAlt,
                  ctlPkg::specClrFpd, ctlPkg::specLoadPc, ctlPkg::specXcryAr0,
                  ctlPkg::specGenCry18, ctlPkg::specStackUpdate, ctlPkg::specArlInd,
                  ctlPkg::specFlagCtl, ctlPkg::specSaveFlags, ctlPkg::specSpMemCycle,
                  ctlPkg::specAdLong};
    cycleNo = 0;
    arstN = 1'b0;
    cram = '0;
    stat = '0;
    ebus = '0;
    pcModel = 1'b0;
    regModel = '0;
    repeat (2) @(posedge CTL);
    arstN <= 1'b1;
    for (cycleNo = 0; cycleNo < numCycles; cycleNo++) begin
      @(posedge CTL);
      driveRandom();
      @(negedge CTL);
      compareOutputs();
      // What the next edge captures
      pcModel = (cram.spec == ctlPkg::specLoadPc || cram.disp == ctlPkg::dispNiCond) &&
                !stat.sbrCall;
      if (ebus.diagStrobe && ebus.ds == {1'b0, ctlPkg::diagLdFunc076}) begin
        regModel = ebus.data;
      end
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* rtl/ctlTop.sv */
// Microcode control decoder
module ctlTop (
  input  logic               CTL,
  input  logic               arstN,
  input  ctlPkg::cramT       cram,
  input  ctlPkg::boardStatT  stat,
  input  ctlPkg::ebusT       ebus,
  output ctlPkg::specT       spec,
  output ctlPkg::regCtlT     regCtl,
  output ctlPkg::diagFuncT   diagFunc,
  output ctlPkg::diagRegT    diagReg,
  output logic               loadPc,
  output logic               adxCry36,
  output ctlPkg::readBusT    readBus
);

  ctlSpecDecode specDecode_i (
    .CTL(CTL), .arstN(arstN), .cram(cram), .stat(stat),
    .spec(spec), .loadPc(loadPc), .adxCry36(adxCry36)
  );

  ctlRegControl regControl_i (
    .cram(cram), .stat(stat), .spec(spec),
    .diagArLoad(diagFunc.diagArLoad), .regCtl(regCtl)
  );

  ctlDiagDecode diagDecode_i (
    .CTL(CTL), .arstN(arstN), .cram(cram), .stat(stat), .ebus(ebus),
    .diagFunc(diagFunc), .diagReg(diagReg)
  );

  ctlDiagRead diagRead_i (
    .spec(spec), .regCtl(regCtl), .diagFunc(diagFunc), .diagReg(diagReg),
    .loadPc(loadPc), .adxCry36(adxCry36), .readBus(readBus)
  );

endmodule

/* rtl/ctlDiagRead.sv */
// Diagnostic read multiplexer
module ctlDiagRead (
  input  ctlPkg::specT      spec,
  input  ctlPkg::regCtlT    regCtl,
  input  ctlPkg::diagFuncT  diagFunc,
  input  ctlPkg::diagRegT   diagReg,
  input  logic              loadPc,
  input  logic              adxCry36,
  output ctlPkg::readBusT   readBus
);

  always_comb begin
    readBus.driving = diagFunc.diagRead;
    readBus.data = '0;
    // Upper four groups of the read 10x table
    if (diagFunc.diagRead && diagFunc.grp[0]) begin
      case (diagFunc.grp[1:2])
        2'd0: readBus.data = {spec.sFlagCtl,
                              loadPc,
                              regCtl.arxlSel[1],
                              regCtl.mqSel[1],
                              regCtl.ar0011Clr};
        2'd1: readBus.data = {spec.sSpMemCycle,
                              spec.sXcryAr0,
                              regCtl.arxlSel[0],
                              regCtl.mqSel[0],
                              regCtl.ar1217Clr};
        2'd2: readBus.data = {spec.adLong,
                              adxCry36,
                              regCtl.arxrSel[1],
                              regCtl.mqmEn,
                              regCtl.arrClr};
        default: readBus.data = {spec.sInhCry18,
                                 diagReg.memReset,
                                 regCtl.arxrSel[0],
                                 diagReg.ldEbusReg,
                                 regCtl.ebusXfer};
      endcase
    end
  end

endmodule

/* rtl/ctlDiagDecode.sv */
// Diagnostic function decode
module ctlDiagDecode (
  input  logic                CTL,
  input  logic                arstN,
  input  ctlPkg::cramT        cram,
  input  ctlPkg::boardStatT   stat,
  input  ctlPkg::ebusT        ebus,
  output ctlPkg::diagFuncT    diagFunc,
  output ctlPkg::diagRegT     diagReg
);

  logic [0:ctlPkg::diagW-1] sel;
  logic ldStrobe;
  logic ld076;

  // Console owns the select unless ds is 00x
  assign diagFunc.consoleControl = ebus.ds[0] | ebus.ds[1];
  assign sel = diagFunc.consoleControl ? ebus.ds : cram.magic.regCtl[2:8];

  assign ldStrobe = ebus.diagStrobe & ~ebus.ds[0];

  always_comb begin
    diagFunc.ctlFunc00x = ldStrobe && (ebus.ds[1:3] == 3'o0);
    diagFunc.ctlFunc01x = ldStrobe && (ebus.ds[1:3] == 3'o1);
    diagFunc.ldFunc04x  = ldStrobe && (ebus.ds[1:3] == 3'o4);
    diagFunc.ldFunc05x  = ldStrobe && (ebus.ds[1:3] == 3'o5);
    diagFunc.ldFunc06x  = ldStrobe && (ebus.ds[1:3] == 3'o6);
    diagFunc.ldFunc07x  = ldStrobe && (ebus.ds[1:3] == 3'o7);
    for (int i = 0; i < 8; i++) begin
      diagFunc.func07x[i] = diagFunc.ldFunc07x && (ebus.ds[4:6] == i[2:0]);
    end
  end

  // Microcode reads on COND diag func
  assign diagFunc.readStrobe = diagFunc.consoleControl ? ebus.diagStrobe
                                                       : stat.condDiagFunc;
  assign diagFunc.readEn = diagFunc.readStrobe & sel[0];
  assign diagFunc.readSel = sel[1:3];
  assign diagFunc.diagRead = diagFunc.readEn & (diagFunc.readSel == 3'o0);
  assign diagFunc.grp = sel[4:6];

  assign diagFunc.diagArLoad = sel[0] & (&ebus.ds[1:3]) & (&sel[4:6]);

  assign ld076 = ldStrobe & (ebus.ds[1:6] == ctlPkg::diagLdFunc076);

  always_ff @(posedge CTL or negedge arstN) begin
    if (!arstN) begin
      diagReg <= '0;
    end else if (ld076) begin
      diagReg <= ctlPkg::diagRegT'(ebus.data);
    end
  end

endmodule

/* rtl/ctlRegControl.sv */
// AR, ARX and MQ register controls
module ctlRegControl (
  input  ctlPkg::cramT      cram,
  input  ctlPkg::boardStatT stat,
  input  ctlPkg::specT      spec,
  input  logic              diagArLoad,
  output ctlPkg::regCtlT    regCtl
);

  logic condArllLoad;
  logic condArlrLoad;
  logic condArrLoad;
  logic condArClr;
  logic condArxClr;
  logic condArlInd;
  logic condRegCtl;
  logic arlInd;
  logic [0:8] rc;
  logic [2:0] indSel;
  logic clrL;
  logic clrR;
  logic shortEa;
  logic ea36;
  logic load1;
  logic fmArLoad;
  logic fmArxLoad;
  logic respMs;
  logic indOrDiag;
  logic armOrDiag;
  logic rstMq;
  logic mathMq;

  // Conditional strobes from COND bits 3 to 5
  assign condArllLoad = stat.condEn & (cram.cond[3:5] == 3'd1);
  assign condArlrLoad = stat.condEn & (cram.cond[3:5] == 3'd2);
  assign condArrLoad  = stat.condEn & (cram.cond[3:5] == 3'd3);
  assign condArClr    = stat.condEn & (cram.cond[3:5] == 3'd4);
  assign condArxClr   = stat.condEn & (cram.cond[3:5] == 3'd5);
  assign condArlInd   = stat.condEn & (cram.cond[3:5] == 3'd6);
  assign condRegCtl   = stat.condEn & (cram.cond[3:5] == 3'd7);

  assign arlInd = stat.memArlInd | spec.sArlInd | condArlInd;

  // Magic is either indirect controls or per-bit enables
  assign rc = (!arlInd && condRegCtl) ? cram.magic.regCtl : '0;
  assign indSel = arlInd ? cram.magic.arlInd.arlSel : cram.ar;
  assign clrL = arlInd ? cram.magic.arlInd.arClrL : condArClr;
  assign clrR = arlInd ? cram.magic.arlInd.arClrR : condArClr;

  assign regCtl.mqClr  = arlInd & cram.magic.arlInd.mqClr;
  assign regCtl.arxClr = arlInd ? cram.magic.arlInd.arxClr : condArxClr;

  // Short EA clears the section bits
  assign shortEa = spec.dEaMod & stat.arx18;
  assign regCtl.ar1217Clr = stat.mrReset | stat.ea18 | clrL | shortEa;
  assign regCtl.ar0011Clr = regCtl.ar1217Clr | stat.ea23;
  assign regCtl.arrClr = stat.mrReset | clrR;
  assign ea36 = spec.dARead & regCtl.ar0011Clr;

  assign fmArLoad  = stat.fmXfer & stat.loadAr;
  assign fmArxLoad = stat.fmXfer & stat.loadArx;
  assign respMs    = stat.respMbox | stat.respSim;
  assign indOrDiag = indSel[0] | diagArLoad;
  assign armOrDiag = cram.ar[2] | diagArLoad;

  assign regCtl.arlSel[2] = indSel[2];
  assign regCtl.arlSel[1] = indSel[1] | ea36 | diagArLoad | fmArLoad;
  assign regCtl.arlSel[0] = (stat.loadAr | indOrDiag) & (indOrDiag | respMs);
  assign regCtl.arrSel[1] = cram.ar[1] | spec.dARead | diagArLoad | fmArLoad;
  assign regCtl.arrSel[0] = (stat.loadAr | armOrDiag) & (armOrDiag | respMs);

  assign load1 = regCtl.ar0011Clr | (|regCtl.arlSel);
  assign regCtl.ar0917Load = condArlrLoad | rc[1] | load1;
  assign regCtl.ar0008Load = condArllLoad | rc[0] | load1 |
                             (arlInd & cram.magic.arlInd.callSel);
  assign regCtl.arrLoad = rc[2] | condArrLoad | regCtl.arrClr | (|regCtl.arrSel);

  assign regCtl.arxlSel[1] = cram.arx[1] | fmArxLoad;
  assign regCtl.arxlSel[0] = (stat.loadArx | cram.arx[2]) & (cram.arx[2] | respMs);
  assign regCtl.arxrSel = regCtl.arxlSel;
  assign regCtl.arxLoad = cram.arx[0] | (|regCtl.arxlSel) | regCtl.arxClr | stat.mrReset;

  assign regCtl.ebusXfer = cram.ar[0] & stat.cono & ~(cram.ar[1] & cram.ar[2]);

  // MQ mux select, MQM path when enabled
  assign rstMq  = stat.mrReset | rc[7] | regCtl.mqClr;
  assign mathMq = regCtl.mqClr | rc[8] | spec.sMqShift | spec.dMul | spec.dDiv;
  assign regCtl.mqmEn = cram.mq | stat.mrReset;
  assign regCtl.mqmSel = {regCtl.mqmEn & rstMq, regCtl.mqmEn & mathMq};
  assign regCtl.mqSel = {~regCtl.mqmEn & rstMq, ~regCtl.mqmEn & mathMq};

endmodule

/* rtl/ctlSpecDecode.sv */
// Dispatch and special decode
module ctlSpecDecode (
  input  logic              CTL,
  input  logic              arstN,
  input  ctlPkg::cramT      cram,
  input  ctlPkg::boardStatT stat,
  output ctlPkg::specT      spec,
  output logic              loadPc,
  output logic              adxCry36
);

  logic loadPcQ;
  logic piSaveFlags;

  always_comb begin
    spec.dARead  = cram.disp == ctlPkg::dispDramARd;
    spec.dReturn = cram.disp == ctlPkg::dispReturn;
    spec.dNiCond = cram.disp == ctlPkg::dispNiCond;
    spec.dMul    = cram.disp == ctlPkg::dispMul;
    spec.dDiv    = cram.disp == ctlPkg::dispDiv;
    spec.dNorm   = cram.disp == ctlPkg::dispNorm;
    spec.dEaMod  = cram.disp == ctlPkg::dispEaMod;

    spec.sInhCry18    = cram.spec == ctlPkg::specInhCry18;
    spec.sMqShift     = cram.spec == ctlPkg::specMqShift;
    spec.sScmAlt      = cram.spec == ctlPkg::specScmAlt;
    spec.sClrFpd      = cram.spec == ctlPkg::specClrFpd;
    spec.sLoadPc      = cram.spec == ctlPkg::specLoadPc;
    spec.sXcryAr0     = cram.spec == ctlPkg::specXcryAr0;
    spec.sGenCry18    = cram.spec == ctlPkg::specGenCry18;
    spec.sStackUpdate = cram.spec == ctlPkg::specStackUpdate;
    spec.sArlInd      = cram.spec == ctlPkg::specArlInd;
    spec.sFlagCtl     = cram.spec == ctlPkg::specFlagCtl;
    spec.sSaveFlags   = cram.spec == ctlPkg::specSaveFlags;
    spec.sSpMemCycle  = cram.spec == ctlPkg::specSpMemCycle;
    spec.sAdLong      = cram.spec == ctlPkg::specAdLong;

    // Double-length adder for the math dispatches
    spec.adLong = spec.dMul | spec.dDiv | spec.dNorm | spec.sAdLong | spec.sMqShift;
    spec.genCry18 = spec.sGenCry18 | (spec.sStackUpdate & stat.shortStack);
  end

  // PI cycle flag save kills the ADX carry in
  assign piSaveFlags = stat.pcPlus1Inh & spec.sSaveFlags;
  assign adxCry36 = ~piSaveFlags & (cram.adCarry ^ (stat.ar0 & spec.sXcryAr0));

  always_ff @(posedge CTL or negedge arstN) begin
    if (!arstN) begin
      loadPcQ <= 1'b0;
    end else begin
      loadPcQ <= (spec.sLoadPc | spec.dNiCond) & ~stat.sbrCall;
    end
  end

  assign loadPc = loadPcQ & ~stat.piCycle;

endmodule

/* rtl/ctlPkg.sv */
// Control decoder definitions
package ctlPkg;

  localparam int dispW  = 5;
  localparam int specW  = 5;
  localparam int magicW = 9;
  localparam int diagW  = 7;
  localparam int readW  = 5;

  // Dispatch field codes (octal, as in the microcode listing)
  localparam logic [dispW-1:0] dispDramARd = 5'o02;
  localparam logic [dispW-1:0] dispReturn  = 5'o03;
  localparam logic [dispW-1:0] dispNiCond  = 5'o06;
  localparam logic [dispW-1:0] dispMul     = 5'o30;
  localparam logic [dispW-1:0] dispDiv     = 5'o31;
  localparam logic [dispW-1:0] dispNorm    = 5'o35;
  localparam logic [dispW-1:0] dispEaMod   = 5'o36;

  // Special function codes
  localparam logic [specW-1:0] specInhCry18    = 5'o11;
  localparam logic [specW-1:0] specMqShift     = 5'o12;
  localparam logic [specW-1:0] specScmAlt      = 5'o13;
  localparam logic [specW-1:0] specClrFpd      = 5'o14;
  localparam logic [specW-1:0] specLoadPc      = 5'o15;
  localparam logic [specW-1:0] specXcryAr0     = 5'o16;
  localparam logic [specW-1:0] specGenCry18    = 5'o17;
  localparam logic [specW-1:0] specStackUpdate = 5'o20;
  localparam logic [specW-1:0] specArlInd      = 5'o22;
  localparam logic [specW-1:0] specFlagCtl     = 5'o24;
  localparam logic [specW-1:0] specSaveFlags   = 5'o25;
  localparam logic [specW-1:0] specSpMemCycle  = 5'o26;
  localparam logic [specW-1:0] specAdLong      = 5'o27;

  // ds bits 1 to 6 of the diagnostic register load
  localparam logic [5:0] diagLdFunc076 = 6'o76;

  // Magic number, MSB is bit 0 as on the prints
  typedef union packed {
    logic [0:magicW-1] regCtl;
    struct packed {
      logic       callSel;
      logic       rsvd;
      logic       mqClr;
      logic       arxClr;
      logic       arClrL;
      logic       arClrR;
      logic [2:0] arlSel;
    } arlInd;
  } magicT;

  typedef struct packed {
    logic [dispW-1:0] disp;
    logic [specW-1:0] spec;
    logic             adCarry;
    logic [0:2]       ar;
    logic [0:2]       arx;
    logic             mq;
    logic [0:5]       cond;
    magicT            magic;
  } cramT;

  // Levels from the other boards
  typedef struct packed {
    logic condEn, piCycle, pcPlus1Inh, fmXfer;
    logic loadAr, loadArx, shortStack, memArlInd;
    logic ea18, ea23, sbrCall, respMbox, respSim;
    logic ar0, arx18, mrReset, condDiagFunc, cono;
  } boardStatT;

  typedef struct packed {
    logic             diagStrobe;
    logic [0:diagW-1] ds;
    logic [0:readW-1] data;
  } ebusT;

  typedef struct packed {
    logic dARead, dReturn, dNiCond, dMul, dDiv, dNorm, dEaMod;
    logic sInhCry18, sMqShift, sScmAlt, sClrFpd, sLoadPc;
    logic sXcryAr0, sGenCry18, sStackUpdate, sArlInd, sFlagCtl;
    logic sSaveFlags, sSpMemCycle, sAdLong;
    logic adLong, genCry18;
  } specT;

  typedef struct packed {
    logic       arrLoad, ar0008Load, ar0917Load;
    logic       ar0011Clr, ar1217Clr, arrClr;
    logic [2:0] arlSel;
    logic [1:0] arrSel;
    logic       arxLoad, arxClr;
    logic [1:0] arxlSel;
    logic [1:0] arxrSel;
    logic       mqClr, mqmEn;
    logic [1:0] mqmSel;
    logic [1:0] mqSel;
    logic       ebusXfer;
  } regCtlT;

  typedef struct packed {
    logic       consoleControl, readStrobe, diagRead, diagArLoad;
    logic       ctlFunc00x, ctlFunc01x;
    logic       ldFunc04x, ldFunc05x, ldFunc06x, ldFunc07x;
    logic [7:0] func07x;
    logic [2:0] readSel;
    logic       readEn;
    // Select bits 4 to 6, the read group
    logic [0:2] grp;
  } diagFuncT;

  typedef struct packed {
    logic memReset, channelClkStop, ldEbusReg, forceExtend, diag4;
  } diagRegT;

  typedef struct packed {
    logic             driving;
    logic [0:readW-1] data;
  } readBusT;

endpackage
